/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rob_backend
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SRCS    := $(shell cat $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation failed"; exit 1; \
	elif grep -q "Verification passed" $(LOG); then echo "simulation passed"; \
	else echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* arch_regfile.sv */
module arch_regfile import rob_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  xlen_t     wdata_i,
	input  reg_addr_t raddr_i,
	output xlen_t     rdata_o
);
	// x0 has no storage
	xlen_t regs_q [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// read is combinational, x0 reads as zero
	assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

endmodule

/* commit_unit.sv */
module commit_unit import rob_pkg::*; (
	input  logic         head_valid_i,
	input  logic         head_ready_i,
	input  op_class_e    head_class_i,
	input  reg_addr_t    head_rd_i,
	input  xlen_t        head_pc_i,
	input  logic         head_pred_taken_i,
	input  cmpl_result_u head_result_i,
	output logic         retire_o,
	output logic         flush_o,
	output logic         rf_we_o,
	output reg_addr_t    rf_waddr_o,
	output xlen_t        rf_wdata_o,
	output logic         commit_valid_o,
	output logic         commit_we_o,
	output reg_addr_t    commit_rd_o,
	output xlen_t        commit_data_o,
	output logic         redirect_valid_o,
	output xlen_t        redirect_pc_o
);
	logic  commit_fire;
	logic  writes_rd;
	logic  rd_write;
	logic  do_redirect;
	xlen_t pc_plus4;
	xlen_t target_pc;
	xlen_t wb_data;

	assign commit_fire = head_valid_i && head_ready_i;
	assign pc_plus4    = head_pc_i + xlen_t'(4);
	assign target_pc   = {head_result_i.br.target, 1'b0};

	// decode the head result by class
	always_comb begin
		writes_rd     = 1'b0;
		do_redirect   = 1'b0;
		wb_data       = '0;
		redirect_pc_o = '0;
		case (head_class_i)
			op_alu, op_load: begin
				writes_rd = 1'b1;
				wb_data   = head_result_i.data;
			end
			op_jalr: begin
				// link value, and the jump is always taken at retirement
				writes_rd     = 1'b1;
				wb_data       = pc_plus4;
				do_redirect   = 1'b1;
				redirect_pc_o = target_pc;
			end
			op_branch: begin
				do_redirect   = (head_result_i.br.taken != head_pred_taken_i);
				redirect_pc_o = head_result_i.br.taken ? target_pc : pc_plus4;
			end
			// stores retire silently
			default: begin
			end
		endcase
	end

	// x0 is never written
	assign rd_write = commit_fire && writes_rd && (head_rd_i != '0);

	assign commit_valid_o   = commit_fire;
	assign commit_we_o      = rd_write;
	assign commit_rd_o      = head_rd_i;
	assign commit_data_o    = wb_data;
	assign rf_we_o          = rd_write;
	assign rf_waddr_o       = head_rd_i;
	assign rf_wdata_o       = wb_data;
	assign redirect_valid_o = commit_fire && do_redirect;
	assign retire_o         = commit_fire;
	assign flush_o          = redirect_valid_o;

endmodule

/* flist.f */
rob_pkg.sv
reorder_buffer.sv
commit_unit.sv
arch_regfile.sv
rob_backend_top.sv
rob_backend_assert.sv
tb_rob_backend.sv

/* reorder_buffer.sv */
module reorder_buffer import rob_pkg::*; #(
	parameter  int rob_depth = 8,
	localparam int tag_w     = $clog2(rob_depth)
) (
	input  logic             clk,
	input  logic             rst,
	// dispatch
	input  logic             dispatch_valid_i,
	input  op_class_e        dispatch_class_i,
	input  reg_addr_t        dispatch_rd_i,
	input  xlen_t            dispatch_pc_i,
	input  logic             dispatch_pred_taken_i,
	output logic [tag_w-1:0] dispatch_tag_o,
	// completion ports
	input  logic             alu_done_i,
	input  logic [tag_w-1:0] alu_tag_i,
	input  xlen_t            alu_result_i,
	input  logic             br_done_i,
	input  logic [tag_w-1:0] br_tag_i,
	input  cmpl_result_u     br_result_i,
	// from commit
	input  logic             retire_i,
	input  logic             flush_i,
	// head view for commit
	output logic             head_valid_o,
	output logic             head_ready_o,
	output op_class_e        head_class_o,
	output reg_addr_t        head_rd_o,
	output xlen_t            head_pc_o,
	output logic             head_pred_taken_o,
	output cmpl_result_u     head_result_o,
	output logic             full_o,
	output logic             empty_o
);
	// pointers carry one extra wrap bit above the index
	logic [tag_w:0] head_q;
	logic [tag_w:0] tail_q;
	logic [tag_w-1:0] head_idx;
	logic [tag_w-1:0] tail_idx;

	logic [rob_depth-1:0] valid_q;
	logic [rob_depth-1:0] ready_q;

	// entry payload
	op_class_e    class_q       [rob_depth];
	reg_addr_t    rd_q          [rob_depth];
	xlen_t        pc_q          [rob_depth];
	logic         pred_taken_q  [rob_depth];
	cmpl_result_u result_q      [rob_depth];

	// completions only land on live entries
	logic alu_hit;
	logic br_hit;

	assign head_idx = head_q[tag_w-1:0];
	assign tail_idx = tail_q[tag_w-1:0];

	assign alu_hit = alu_done_i && valid_q[alu_tag_i];
	assign br_hit  = br_done_i && valid_q[br_tag_i];

	assign empty_o = (head_q == tail_q);
	assign full_o  = (head_idx == tail_idx) && (head_q[tag_w] != tail_q[tag_w]);

	assign dispatch_tag_o = tail_idx;

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			// a flush also drops any dispatch in the same cycle
			head_q  <= '0;
			tail_q  <= '0;
			valid_q <= '0;
			ready_q <= '0;
		end else begin
			if (alu_hit) begin
				ready_q[alu_tag_i] <= 1'b1;
			end
			if (br_hit) begin
				ready_q[br_tag_i] <= 1'b1;
			end
			if (dispatch_valid_i) begin
				valid_q[tail_idx] <= 1'b1;
				ready_q[tail_idx] <= 1'b0;
				tail_q            <= tail_q + 1'b1;
			end
			if (retire_i) begin
				valid_q[head_idx] <= 1'b0;
				head_q            <= head_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch_valid_i) begin
			class_q[tail_idx]      <= dispatch_class_i;
			rd_q[tail_idx]         <= dispatch_rd_i;
			pc_q[tail_idx]         <= dispatch_pc_i;
			pred_taken_q[tail_idx] <= dispatch_pred_taken_i;
		end
		if (alu_hit) begin
			result_q[alu_tag_i].data <= alu_result_i;
		end
		if (br_hit) begin
			result_q[br_tag_i] <= br_result_i;
		end
	end

	// combinational head view
	assign head_valid_o      = valid_q[head_idx];
	assign head_ready_o      = ready_q[head_idx];
	assign head_class_o      = class_q[head_idx];
	assign head_rd_o         = rd_q[head_idx];
	assign head_pc_o         = pc_q[head_idx];
	assign head_pred_taken_o = pred_taken_q[head_idx];
	assign head_result_o     = result_q[head_idx];

endmodule

/* rob_backend_assert.sv */
module rob_backend_assert (
	input logic clk,
	input logic rst,
	input logic dispatch_valid_i,
	input logic full_i,
	input logic empty_i,
	input logic flush_i,
	input logic retire_i,
	input logic head_valid_i
);
	int full_fails   = 0;
	int flush_fails  = 0;
	int retire_fails = 0;
	int status_fails = 0;
	int fail_total;

	assign fail_total = full_fails + flush_fails + retire_fails + status_fails;

	a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
		!(dispatch_valid_i && full_i))
		else begin
			$error("dispatch while the buffer is full");
			full_fails++;
		end

	// a dispatch during a redirect would be dropped by the flush
	a_no_dispatch_flush: assert property (@(posedge clk) disable iff (rst)
		!(dispatch_valid_i && flush_i))
		else begin
			$error("dispatch during a redirect");
			flush_fails++;
		end

	// the pointers must also see a live entry at the head
	a_retire_valid: assert property (@(posedge clk) disable iff (rst)
		retire_i |-> (head_valid_i && !empty_i))
		else begin
			$error("retire with no valid head entry");
			retire_fails++;
		end

	// status flags agree with the valid bit at the head
	a_status_head: assert property (@(posedge clk) disable iff (rst)
		!(empty_i && head_valid_i) && !(full_i && !head_valid_i))
		else begin
			$error("status flags disagree with the head entry");
			status_fails++;
		end

endmodule

bind reorder_buffer rob_backend_assert u_assert (
	.clk(clk), .rst(rst), .dispatch_valid_i(dispatch_valid_i),
	.full_i(full_o), .empty_i(empty_o), .flush_i(flush_i),
	.retire_i(retire_i), .head_valid_i(head_valid_o)
);

/* rob_backend_top.sv */
module rob_backend_top import rob_pkg::*; #(
	parameter  int rob_depth = 8,
	localparam int tag_w     = $clog2(rob_depth)
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             dispatch_valid_i,
	input  op_class_e        dispatch_class_i,
	input  reg_addr_t        dispatch_rd_i,
	input  xlen_t            dispatch_pc_i,
	input  logic             dispatch_pred_taken_i,
	output logic [tag_w-1:0] dispatch_tag_o,
	input  logic             alu_done_i,
	input  logic [tag_w-1:0] alu_tag_i,
	input  xlen_t            alu_result_i,
	input  logic             br_done_i,
	input  logic [tag_w-1:0] br_tag_i,
	input  cmpl_result_u     br_result_i,
	output logic             commit_valid_o,
	output logic             commit_we_o,
	output reg_addr_t        commit_rd_o,
	output xlen_t            commit_data_o,
	output logic             redirect_valid_o,
	output xlen_t            redirect_pc_o,
	output logic             rob_full_o,
	output logic             rob_empty_o,
	input  reg_addr_t        rf_raddr_i,
	output xlen_t            rf_rdata_o
);
	// head view of the buffer
	logic         head_valid;
	logic         head_ready;
	op_class_e    head_class;
	reg_addr_t    head_rd;
	xlen_t        head_pc;
	logic         head_pred_taken;
	cmpl_result_u head_result;

	logic      retire;
	logic      flush;
	logic      rf_we;
	reg_addr_t rf_waddr;
	xlen_t     rf_wdata;

	reorder_buffer #(.rob_depth(rob_depth)) u_rob (
		.clk(clk), .rst(rst),
		.dispatch_valid_i(dispatch_valid_i), .dispatch_class_i(dispatch_class_i),
		.dispatch_rd_i(dispatch_rd_i), .dispatch_pc_i(dispatch_pc_i),
		.dispatch_pred_taken_i(dispatch_pred_taken_i), .dispatch_tag_o(dispatch_tag_o),
		.alu_done_i(alu_done_i), .alu_tag_i(alu_tag_i), .alu_result_i(alu_result_i),
		.br_done_i(br_done_i), .br_tag_i(br_tag_i), .br_result_i(br_result_i),
		.retire_i(retire), .flush_i(flush),
		.head_valid_o(head_valid), .head_ready_o(head_ready), .head_class_o(head_class),
		.head_rd_o(head_rd), .head_pc_o(head_pc), .head_pred_taken_o(head_pred_taken),
		.head_result_o(head_result), .full_o(rob_full_o), .empty_o(rob_empty_o)
	);

	commit_unit u_commit (
		.head_valid_i(head_valid), .head_ready_i(head_ready), .head_class_i(head_class),
		.head_rd_i(head_rd), .head_pc_i(head_pc), .head_pred_taken_i(head_pred_taken),
		.head_result_i(head_result), .retire_o(retire), .flush_o(flush),
		.rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
		.commit_valid_o(commit_valid_o), .commit_we_o(commit_we_o),
		.commit_rd_o(commit_rd_o), .commit_data_o(commit_data_o),
		.redirect_valid_o(redirect_valid_o), .redirect_pc_o(redirect_pc_o)
	);

	arch_regfile u_regfile (
		.clk(clk), .rst(rst),
		.we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
		.raddr_i(rf_raddr_i), .rdata_o(rf_rdata_o)
	);

endmodule

/* rob_pkg.sv */
package rob_pkg;

	// data and pc width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] xlen_t;

	// architectural register index, x0 to x31
	typedef logic [4:0] reg_addr_t;

	// tells commit how to retire an entry
	typedef enum logic [2:0] {
		op_alu    = 3'd0,
		op_load   = 3'd1,
		op_store  = 3'd2,
		op_branch = 3'd3,
		op_jalr   = 3'd4
	} op_class_e;

	// branch port outcome
	// targets are at least halfword aligned, so bit 0 is free for the taken flag
	typedef struct packed {
		logic [xlen-1:1] target;
		logic            taken;
	} br_outcome_t;

	// one completion word
	// alu port writes plain data, branch port writes an outcome
	// for jalr only the target field is meaningful
	typedef union packed {
		xlen_t       data;
		br_outcome_t br;
	} cmpl_result_u;

endpackage

/* rob_vectors.txt */
# D class rd pc pred | A tag data | B tag taken target | C we rd data | R pc | F | W
# G addr value | class 0 alu, 1 load, 2 store, 3 branch, 4 jalr | numbers in hex
D 0 01 00000100 0
D 1 02 00000104 0
D 2 0e 00000108 0
D 0 00 0000010c 0
D 0 03 00000110 0
D 2 0f 00000114 0
D 0 04 00000118 0
D 1 05 0000011c 0
F
A 5 0badf00d
A 2 12345678
A 7 55555555
A 0 11111111
A 3 deadbeef
A 6 44444444
A 1 22222222
A 4 33333333
C 1 01 11111111
C 1 02 22222222
C 0 0e 00000000
C 0 00 00000000
C 1 03 33333333
C 0 0f 00000000
C 1 04 44444444
C 1 05 55555555
W
G 00 00000000
G 01 11111111
G 0e 00000000
D 3 00 00000200 1
B 0 1 00000300
C 0 00 00000000
D 3 00 00000210 0
D 0 06 00000214 0
A 2 66666666
B 1 1 00000400
C 0 00 00000000
R 00000400
D 3 00 00000500 1
B 0 0 00000600
C 0 00 00000000
R 00000504
D 4 08 00000700 0
B 0 1 00000880
C 1 08 00000704
R 00000880
W
G 08 00000704
G 06 00000000

/* tb_rob_backend.sv */
module tb_rob_backend import rob_pkg::*; ();
	localparam int rob_depth = 8;
	localparam int tag_w     = $clog2(rob_depth);

	logic             clk;
	logic             rst;
	logic             dispatch_valid;
	op_class_e        dispatch_class;
	reg_addr_t        dispatch_rd;
	xlen_t            dispatch_pc;
	logic             dispatch_pred_taken;
	logic [tag_w-1:0] dispatch_tag;
	logic             alu_done;
	logic [tag_w-1:0] alu_tag;
	xlen_t            alu_result;
	logic             br_done;
	logic [tag_w-1:0] br_tag;
	cmpl_result_u     br_result;
	logic             commit_valid;
	logic             commit_we;
	reg_addr_t        commit_rd;
	xlen_t            commit_data;
	logic             redirect_valid;
	xlen_t            redirect_pc;
	logic             rob_full;
	logic             rob_empty;
	reg_addr_t        rf_raddr;
	xlen_t            rf_rdata;

	// vector lines and observed retirements
	logic [7:0] v_op [$];
	xlen_t      v_a [$];
	xlen_t      v_b [$];
	xlen_t      v_c [$];
	xlen_t      v_d [$];
	logic       q_we [$];
	reg_addr_t  q_rd [$];
	xlen_t      q_data [$];
	xlen_t      q_redir [$];

	// dispatches since reset or the last redirect
	int disp_count  = 0;
	int cycles      = 0;
	int cycle_limit = 0;

	rob_backend_top #(.rob_depth(rob_depth)) dut0 (
		.clk(clk), .rst(rst),
		.dispatch_valid_i(dispatch_valid), .dispatch_class_i(dispatch_class),
		.dispatch_rd_i(dispatch_rd), .dispatch_pc_i(dispatch_pc),
		.dispatch_pred_taken_i(dispatch_pred_taken), .dispatch_tag_o(dispatch_tag),
		.alu_done_i(alu_done), .alu_tag_i(alu_tag), .alu_result_i(alu_result),
		.br_done_i(br_done), .br_tag_i(br_tag), .br_result_i(br_result),
		.commit_valid_o(commit_valid), .commit_we_o(commit_we),
		.commit_rd_o(commit_rd), .commit_data_o(commit_data),
		.redirect_valid_o(redirect_valid), .redirect_pc_o(redirect_pc),
		.rob_full_o(rob_full), .rob_empty_o(rob_empty),
		.rf_raddr_i(rf_raddr), .rf_rdata_o(rf_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_tag(input logic [tag_w-1:0] got, input logic [tag_w-1:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("Fail at %0t: dispatch tag got %0d expected %0d",
				$time, got, exp));
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			report_failure($sformatf("Fail at %0t: %s got %0b expected %0b",
				$time, what, got, exp));
		end
	endtask

	// data only matters when the entry writes a register
	task automatic check_commit(input logic got_we, input reg_addr_t got_rd,
		input xlen_t got_data, input logic exp_we, input reg_addr_t exp_rd,
		input xlen_t exp_data);
		if (got_we !== exp_we || got_rd !== exp_rd || (exp_we && got_data !== exp_data)) begin
			report_failure($sformatf(
				"Fail at %0t: commit we=%0b rd=%0d data=%h, expected we=%0b rd=%0d data=%h",
				$time, got_we, got_rd, got_data, exp_we, exp_rd, exp_data));
		end
	endtask

	task automatic check_redirect(input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			report_failure($sformatf("Fail at %0t: redirect pc %h expected %h",
				$time, got, exp));
		end
	endtask

	task automatic check_reg(input reg_addr_t addr, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			report_failure($sformatf("Fail at %0t: x%0d reads %h expected %h",
				$time, addr, got, exp));
		end
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		int want;
		logic [7:0] op;
		xlen_t a;
		xlen_t b;
		xlen_t c;
		xlen_t d;
		logic [8*256-1:0] rest;
		fd = $fopen("rob_vectors.txt", "r");
		if (fd == 0) begin
			report_failure("could not open rob_vectors.txt");
		end
		while ($fscanf(fd, " %c", op) == 1) begin
			a = '0;
			b = '0;
			c = '0;
			d = '0;
			if (op == "#") begin
				n = $fgets(rest, fd);
			end else begin
				want = 0;
				case (op)
					"D": begin
						n    = $fscanf(fd, " %h %h %h %h", a, b, c, d);
						want = 4;
					end
					"A", "G": begin
						n    = $fscanf(fd, " %h %h", a, b);
						want = 2;
					end
					"B", "C": begin
						n    = $fscanf(fd, " %h %h %h", a, b, c);
						want = 3;
					end
					"R": begin
						n    = $fscanf(fd, " %h", a);
						want = 1;
					end
					default: n = 0;
				endcase
				if (n != want) begin
					report_failure($sformatf("malformed %c line in rob_vectors.txt", op));
				end
				v_op.push_back(op);
				v_a.push_back(a);
				v_b.push_back(b);
				v_c.push_back(c);
				v_d.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	task automatic apply_line(input logic [7:0] op, input xlen_t a, input xlen_t b,
		input xlen_t c, input xlen_t d);
		case (op)
			"D": begin
				check_tag(dispatch_tag, tag_w'(disp_count % rob_depth));
				dispatch_valid      = 1'b1;
				dispatch_class      = op_class_e'(a[2:0]);
				dispatch_rd         = b[4:0];
				dispatch_pc         = c;
				dispatch_pred_taken = d[0];
				@(negedge clk);
				dispatch_valid = 1'b0;
				disp_count++;
			end
			"A": begin
				alu_done   = 1'b1;
				alu_tag    = a[tag_w-1:0];
				alu_result = b;
				@(negedge clk);
				alu_done = 1'b0;
			end
			"B": begin
				br_done             = 1'b1;
				br_tag              = a[tag_w-1:0];
				br_result.br.taken  = b[0];
				br_result.br.target = c[31:1];
				@(negedge clk);
				br_done = 1'b0;
			end
			"C": begin
				while (q_we.size() == 0) @(negedge clk);
				check_commit(q_we.pop_front(), q_rd.pop_front(), q_data.pop_front(),
					a[0], b[4:0], c);
			end
			"R": begin
				while (q_redir.size() == 0) @(negedge clk);
				check_redirect(q_redir.pop_front(), a);
				// the buffer was cleared at the redirect edge
				disp_count = 0;
			end
			"F": check_flag(rob_full, 1'b1, "rob_full_o");
			"G": begin
				rf_raddr = a[4:0];
				@(negedge clk);
				check_reg(a[4:0], rf_rdata, b);
			end
			"W": begin
				while (!rob_empty) @(negedge clk);
				if (q_we.size() != 0 || q_redir.size() != 0) begin
					report_failure($sformatf("Fail at %0t: unexpected commit or redirect",
						$time));
				end
			end
			default: report_failure("unknown operation in rob_vectors.txt");
		endcase
	endtask

	// retirement monitor
	always @(posedge clk) begin
		if (!rst && commit_valid) begin
			q_we.push_back(commit_we);
			q_rd.push_back(commit_rd);
			q_data.push_back(commit_data);
		end
		if (!rst && redirect_valid) begin
			q_redir.push_back(redirect_pc);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			report_failure($sformatf("timeout, the run did not finish within %0d cycles",
				cycle_limit));
		end
		if (dut0.u_rob.u_assert.fail_total != 0) begin
			report_failure("a protocol assertion failed in the reorder buffer");
		end
	end

	initial begin
		void'($urandom(66192));
		rst                 = 1'b1;
		dispatch_valid      = 1'b0;
		dispatch_class      = op_alu;
		dispatch_rd         = '0;
		dispatch_pc         = '0;
		dispatch_pred_taken = 1'b0;
		alu_done            = 1'b0;
		alu_tag             = '0;
		alu_result          = '0;
		br_done             = 1'b0;
		br_tag              = '0;
		br_result           = '0;
		rf_raddr            = '0;
		load_vectors();
		cycle_limit = 20 * v_op.size() + 200;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		check_flag(rob_empty, 1'b1, "rob_empty_o after reset");
		check_flag(rob_full, 1'b0, "rob_full_o after reset");
		check_flag(commit_valid | redirect_valid, 1'b0, "commit or redirect after reset");
		for (int i = 0; i < v_op.size(); i++) begin
			apply_line(v_op[i], v_a[i], v_b[i], v_c[i], v_d[i]);
			// idle gap between lines
			repeat ($urandom % 3) @(negedge clk);
		end
		if (dut0.u_rob.u_assert.fail_total == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			report_failure("a protocol assertion failed in the reorder buffer");
		end
	end

endmodule
